// File: pe_array.f
+incdir+rtl
rtl/pe_pkg.sv
rtl/mod_addsub.sv
rtl/mod_mul.sv
rtl/delay_line.sv
rtl/pe_lane.sv
rtl/pe_array.sv
verification/pe_array_assert.sv
verification/pe_array_tb.sv

// File: rtl/delay_line.sv
/*
 * register chain of DEPTH stages
 * aligns operands and flags across the pipeline
 */
`timescale 1ns/100ps

module delay_line #(
    parameter int WIDTH = 1,
    parameter int DEPTH = 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] d,
    output logic [WIDTH-1:0] q
);

    logic [WIDTH-1:0] regs [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else begin
            regs[0] <= d;
            for (int i = 1; i < DEPTH; i++) begin
                regs[i] <= regs[i-1];
            end
        end
    end

    assign q = regs[DEPTH-1];

endmodule

// File: rtl/mod_addsub.sv
/*
 * modular adder and subtractor mod q
 * sum and difference registered together, one correction step each
 */
`timescale 1ns/100ps
`include "pe_defines.svh"

module mod_addsub (
    input  logic          clk,
    input  logic          rst,
    input  pe_pkg::coef_t a,
    input  pe_pkg::coef_t b,
    output pe_pkg::coef_t sum,
    output pe_pkg::coef_t diff
);

    localparam logic [`PE_COEF_W:0] q_ext = `PE_Q;

    logic [`PE_COEF_W:0] sum_raw;   // carry kept
    logic [`PE_COEF_W:0] diff_raw;  // msb is the borrow
    logic [`PE_COEF_W:0] sum_red;
    logic [`PE_COEF_W:0] diff_red;

    always_comb begin
        sum_raw  = {1'b0, a} + {1'b0, b};
        diff_raw = {1'b0, a} - {1'b0, b};
        sum_red  = (sum_raw >= q_ext) ? sum_raw - q_ext : sum_raw;
        // wrap back into range on borrow
        diff_red = diff_raw[`PE_COEF_W] ? diff_raw + q_ext : diff_raw;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sum  <= '0;
            diff <= '0;
        end else begin
            sum  <= sum_red[`PE_COEF_W-1:0];
            diff <= diff_red[`PE_COEF_W-1:0];
        end
    end

endmodule

// File: rtl/mod_mul.sv
/*
 * modular multiplier mod q, three pipeline stages
 * product, Barrett quotient estimate, remainder with one final correction
 */
`timescale 1ns/100ps
`include "pe_defines.svh"

module mod_mul (
    input  logic          clk,
    input  logic          rst,
    input  pe_pkg::coef_t a,
    input  pe_pkg::coef_t b,
    output pe_pkg::coef_t p
);

    import pe_pkg::*;

    // product times the 13-bit Barrett constant
    localparam int est_w = `PE_PROD_W + 13;
    localparam logic [`PE_COEF_W:0] q_ext = `PE_Q;

    prod_t               prod_s1;
    prod_t               prod_s2;
    coef_t               quot_s2;
    logic [est_w-1:0]    est;
    prod_t               quot_q;
    logic [`PE_COEF_W:0] rem;
    logic [`PE_COEF_W:0] rem_red;

    always_comb begin
        est = est_w'(prod_s1) * est_w'(`PE_BARRETT_M);
        quot_q = quot_s2 * prod_t'(`PE_Q);
        // true remainder is below 2q, so 13 low bits are exact
        rem = prod_s2[`PE_COEF_W:0] - quot_q[`PE_COEF_W:0];
        rem_red = (rem >= q_ext) ? rem - q_ext : rem;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prod_s1 <= '0;
            prod_s2 <= '0;
            quot_s2 <= '0;
            p       <= '0;
        end else begin
            prod_s1 <= a * b;                               // stage 1
            prod_s2 <= prod_s1;                             // stage 2
            quot_s2 <= est[`PE_BARRETT_K +: `PE_COEF_W];  // floor(x*m / 2^k)
            p       <= rem_red[`PE_COEF_W-1:0];             // stage 3
        end
    end

endmodule

// File: rtl/pe_array.sv
/*
 * top of the NTT processing-element array
 * replicated lanes and the valid pipeline
 */
`timescale 1ns/100ps
`include "pe_defines.svh"

module pe_array (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                valid_in,
    input  pe_pkg::pe_op_t                      op,
    input  pe_pkg::lane_in_t  [`PE_LANES-1:0]   lanes_in,
    output logic                                valid_out,
    output pe_pkg::lane_out_t [`PE_LANES-1:0]   lanes_out
);

    // all lanes share one op code per cycle
    for (genvar i = 0; i < `PE_LANES; i++) begin : g_lane
        pe_lane u_lane (
            .clk  (clk),
            .rst  (rst),
            .op   (op),
            .din  (lanes_in[i]),
            .dout (lanes_out[i])
        );
    end

    // valid follows the data through the same number of stages
    delay_line #(
        .WIDTH (1),
        .DEPTH (`PE_LATENCY)
    ) u_valid_dly (
        .clk (clk),
        .rst (rst),
        .d   (valid_in),
        .q   (valid_out)
    );

endmodule

// File: rtl/pe_defines.svh
/*
 * constants for the NTT processing-element array
 * Kyber modulus, Barrett reduction constants, widths, lane count, latencies
 */
`ifndef PE_DEFINES_SVH
`define PE_DEFINES_SVH

// Kyber prime and coefficient sizes
`define PE_Q          3329
`define PE_COEF_W     12
`define PE_PROD_W     24

// floor(2^24 / q) and its shift
`define PE_BARRETT_M  5039
`define PE_BARRETT_K  24

`define PE_LANES      4
// mod_mul depth, and issue to result for every op
`define PE_MUL_LAT    3
`define PE_LATENCY    5

`endif

// File: rtl/pe_lane.sv
/*
 * one processing element of the NTT array
 * early add/sub, Barrett multiplier, late add/sub, op code pipeline, result select
 */
`timescale 1ns/100ps
`include "pe_defines.svh"

module pe_lane (
    input  logic              clk,
    input  logic              rst,
    input  pe_pkg::pe_op_t    op,
    input  pe_pkg::lane_in_t  din,
    output pe_pkg::lane_out_t dout
);

    import pe_pkg::*;

    // a and the early results wait out the multiplier plus one stage
    localparam int align_depth = `PE_MUL_LAT + 1;

    pe_op_t    op_pipe [`PE_LATENCY];
    coef_t     early_sum;
    coef_t     early_diff;
    lane_in_t  din_d1;
    lane_out_t early_dly;  // x carries sum, y carries diff
    coef_t     a_d4;
    coef_t     mul_a;
    coef_t     mul_b;
    coef_t     prod;
    coef_t     late_a;
    coef_t     late_b;
    coef_t     late_sum;
    coef_t     late_diff;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `PE_LATENCY; i++) begin
                op_pipe[i] <= OP_MADD;
            end
        end else begin
            op_pipe[0] <= op;
            for (int i = 1; i < `PE_LATENCY; i++) begin
                op_pipe[i] <= op_pipe[i-1];
            end
        end
    end

    mod_addsub u_early (.clk(clk), .rst(rst), .a(din.a), .b(din.b),
                        .sum(early_sum), .diff(early_diff));

    delay_line #(.WIDTH($bits(lane_in_t)), .DEPTH(1)) u_abw_dly (
        .clk(clk), .rst(rst), .d(din), .q(din_d1));

    delay_line #(.WIDTH(`PE_COEF_W), .DEPTH(align_depth)) u_a_dly (
        .clk(clk), .rst(rst), .d(din.a), .q(a_d4));

    delay_line #(.WIDTH(2 * `PE_COEF_W), .DEPTH(align_depth)) u_early_dly (
        .clk(clk), .rst(rst), .d({early_sum, early_diff}), .q(early_dly));

    // stage 1 multiplier operands
    always_comb begin
        case (op_pipe[0])
            OP_GS_BFO: begin
                mul_a = early_diff;  // (a-b)*w
                mul_b = din_d1.w;
            end
            OP_CT_BFO: begin
                mul_a = din_d1.b;
                mul_b = din_d1.w;
            end
            default: begin
                mul_a = din_d1.a;
                mul_b = din_d1.b;
            end
        endcase
    end

    mod_mul u_mul (.clk(clk), .rst(rst), .a(mul_a), .b(mul_b), .p(prod));

    // stage 4, product passes through unchanged unless CT
    assign late_a = (op_pipe[3] == OP_CT_BFO) ? a_d4 : prod;
    assign late_b = (op_pipe[3] == OP_CT_BFO) ? prod : '0;

    mod_addsub u_late (.clk(clk), .rst(rst), .a(late_a), .b(late_b),
                       .sum(late_sum), .diff(late_diff));

    // stage 5 result select
    always_comb begin
        dout = '0;
        case (op_pipe[4])
            OP_MADD:   dout.x = early_dly.x;
            OP_MSUB:   dout.x = early_dly.y;
            OP_MMUL:   dout.x = late_sum;
            OP_CT_BFO: begin
                dout.x = late_sum;
                dout.y = late_diff;
            end
            OP_GS_BFO: begin
                dout.x = early_dly.x;
                dout.y = late_sum;
            end
            default:   dout = '0;
        endcase
    end

endmodule

// File: rtl/pe_pkg.sv
/*
 * types for the NTT processing-element array
 * coefficient and product vectors, operation codes, lane operand/result structs
 */
package pe_pkg;

`include "pe_defines.svh"

    typedef logic [`PE_COEF_W-1:0] coef_t;  // value mod q
    typedef logic [`PE_PROD_W-1:0] prod_t;  // unreduced a*b

    typedef enum logic [2:0] {
        OP_MADD   = 3'd0,
        OP_MSUB   = 3'd1,
        OP_MMUL   = 3'd2,
        OP_CT_BFO = 3'd3,
        OP_GS_BFO = 3'd4
    } pe_op_t;

    typedef struct packed {
        coef_t a;
        coef_t b;
        coef_t w;  // twiddle
    } lane_in_t;

    typedef struct packed {
        coef_t x;
        coef_t y;
    } lane_out_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# build the pe_array testbench with Verilator, run it, look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module pe_array_tb -f pe_array.f -Mdir obj_dir

./obj_dir/Vpe_array_tb | tee sim.log

grep -q "^TEST RESULT: PASS$" sim.log
echo "simulation passed"

// File: verification/pe_array_assert.sv
/*
 * assertions bound to the NTT array top
 * valid quiet in reset, valid latency, results reduced below q
 */
`timescale 1ns/100ps
`include "pe_defines.svh"

module pe_array_assert (
    input logic                              clk,
    input logic                              rst,
    input logic                              valid_in,
    input logic                              valid_out,
    input pe_pkg::lane_out_t [`PE_LANES-1:0] lanes_out
);

    import pe_pkg::*;

    // one cycle of reset clears the valid pipe
    a_reset_quiet: assert property (@(posedge clk) rst |=> !valid_out)
        else $error("valid_out high after a reset cycle");

    a_valid_delay: assert property (@(posedge clk) disable iff (rst)
        valid_out == $past(valid_in, `PE_LATENCY))
        else $error("valid_out does not follow valid_in by the pipe latency");

    for (genvar i = 0; i < `PE_LANES; i++) begin : g_range
        a_below_q: assert property (@(posedge clk) disable iff (rst)
            valid_out |-> (lanes_out[i].x < coef_t'(`PE_Q) && lanes_out[i].y < coef_t'(`PE_Q)))
            else $error("lane %0d result not reduced below q", i);
    end

endmodule

// File: verification/pe_array_tb.sv
/*
 * testbench for the NTT processing-element array
 * clock and reset, directed table, LFSR random items, reference model, result checks
 */
`timescale 1ns/100ps
`include "pe_defines.svh"

module pe_array_tb;

    import pe_pkg::*;

    localparam int n_rows      = 12;
    localparam int n_rand      = 200;
    localparam int q           = `PE_Q;
    localparam int drain_limit = 50;

    typedef lane_in_t  [`PE_LANES-1:0] lanes_in_t;
    typedef lane_out_t [`PE_LANES-1:0] lanes_out_t;

    typedef struct packed {
        pe_op_t                op;
        logic                  valid;
        coef_t [`PE_LANES-1:0] a;  // lane 3 first
        coef_t [`PE_LANES-1:0] b;
        coef_t [`PE_LANES-1:0] w;
    } row_t;

    logic        clk;
    logic        rst;
    logic        valid_in;
    pe_op_t      op;
    lanes_in_t   lanes_in;
    logic        valid_out;
    lanes_out_t  lanes_out;

    row_t        rows [n_rows];
    lanes_out_t  exp_q [$];
    int          stamp_q [$];
    logic [31:0] lfsr_state = 32'hae3f;
    int          cycle_cnt = 0;  // counts falling edges
    int          checks = 0;
    int          errors = 0;
    int          issued = 0;
    int          results = 0;

    pe_array DUT (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_in),
        .op        (op),
        .lanes_in  (lanes_in),
        .valid_out (valid_out),
        .lanes_out (lanes_out)
    );

    bind pe_array pe_array_assert u_assert (.clk(clk), .rst(rst), .valid_in(valid_in),
                                            .valid_out(valid_out), .lanes_out(lanes_out));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Galois LFSR on x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic draw_coef(output coef_t c);
        logic [31:0] v;
        draw_bits(`PE_COEF_W, v);
        c = (v >= q) ? coef_t'(v - q) : coef_t'(v);
    endtask

    // expected x and y straight from the modular definitions
    function automatic lane_out_t ref_lane(input pe_op_t o, input int a, input int b,
                                           input int w);
        int t;
        int x;
        int y;
        y = 0;
        case (o)
            OP_MADD: x = (a + b) % q;
            OP_MSUB: x = (a - b + q) % q;
            OP_MMUL: x = (a * b) % q;
            OP_CT_BFO: begin
                t = (b * w) % q;
                x = (a + t) % q;
                y = (a - t + q) % q;
            end
            default: begin  // GS butterfly
                x = (a + b) % q;
                y = (((a - b + q) % q) * w) % q;
            end
        endcase
        return '{x: coef_t'(x), y: coef_t'(y)};
    endfunction

    task automatic check_equal(input string what, input int got, input int expv);
        checks++;
        if (got != expv) begin
            errors++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, expv);
        end
    endtask

    task automatic issue(input pe_op_t o, input logic v, input lanes_in_t l);
        lanes_out_t e;
        @(posedge clk);
        valid_in <= v;
        op       <= o;
        lanes_in <= l;
        if (v) begin
            for (int i = 0; i < `PE_LANES; i++) begin
                e[i] = ref_lane(o, int'(l[i].a), int'(l[i].b), int'(l[i].w));
            end
            exp_q.push_back(e);
            stamp_q.push_back(cycle_cnt + 1);  // next falling edge sees it at the input
            issued++;
        end
    endtask

    task automatic load_table();
        rows[0]  = '{OP_MADD, 1'b1, {12'd3328, 12'd0, 12'd1, 12'd1234},
                     {12'd1, 12'd0, 12'd3328, 12'd2000}, {4{12'd0}}};
        rows[1]  = '{OP_MSUB, 1'b1, {12'd0, 12'd3328, 12'd5, 12'd100},
                     {12'd1, 12'd3328, 12'd7, 12'd99}, {4{12'd0}}};
        rows[2]  = '{OP_MMUL, 1'b1, {12'd3328, 12'd1, 12'd0, 12'd1234},
                     {12'd3328, 12'd3328, 12'd17, 12'd2345}, {4{12'd0}}};
        rows[3]  = '{OP_MADD, 1'b0, {4{12'd7}}, {4{12'd9}}, {4{12'd0}}};  // bubble
        rows[4]  = '{OP_CT_BFO, 1'b1, {12'd0, 12'd3328, 12'd1, 12'd2500},
                     {12'd1, 12'd3328, 12'd0, 12'd1700}, {12'd3328, 12'd3328, 12'd17, 12'd1}};
        rows[5]  = '{OP_GS_BFO, 1'b1, {12'd0, 12'd3328, 12'd1, 12'd42},
                     {12'd1, 12'd0, 12'd3328, 12'd3000}, {12'd3328, 12'd2, 12'd1, 12'd1729}};
        rows[6]  = '{OP_MMUL, 1'b0, {4{12'd11}}, {4{12'd13}}, {4{12'd0}}};
        rows[7]  = '{OP_GS_BFO, 1'b0, {4{12'd3}}, {4{12'd5}}, {4{12'd8}}};
        rows[8]  = '{OP_MMUL, 1'b1, {12'd1, 12'd3328, 12'd2, 12'd1000},
                     {12'd1, 12'd2, 12'd1665, 12'd1000}, {4{12'd0}}};
        rows[9]  = '{OP_CT_BFO, 1'b1, {12'd1234, 12'd5, 12'd0, 12'd3328},
                     {12'd0, 12'd3328, 12'd3328, 12'd1}, {12'd999, 12'd1, 12'd3328, 12'd3328}};
        rows[10] = '{OP_GS_BFO, 1'b1, {12'd3328, 12'd0, 12'd17, 12'd100},
                     {12'd3328, 12'd3328, 12'd16, 12'd200}, {12'd0, 12'd5, 12'd3328, 12'd1}};
        rows[11] = '{OP_MSUB, 1'b1, {12'd1, 12'd2, 12'd3, 12'd4},
                     {12'd3328, 12'd3327, 12'd3326, 12'd3325}, {4{12'd0}}};
    endtask

    always @(negedge clk) begin : monitor
        lanes_out_t e;
        int         stamp;
        cycle_cnt = cycle_cnt + 1;
        if (valid_out) begin
            results++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("valid_out went high at %0t ns with no item in flight", $time);
            end else begin
                e     = exp_q.pop_front();
                stamp = stamp_q.pop_front();
                check_equal("latency in cycles", cycle_cnt - stamp, `PE_LATENCY);
                for (int i = 0; i < `PE_LANES; i++) begin
                    check_equal($sformatf("lane %0d x", i), int'(lanes_out[i].x), int'(e[i].x));
                    check_equal($sformatf("lane %0d y", i), int'(lanes_out[i].y), int'(e[i].y));
                end
            end
        end
    end

    initial begin : stimulus
        lanes_in_t   l;
        coef_t       c;
        logic [31:0] v;
        int          waited;
        rst      = 1'b1;
        valid_in = 1'b0;
        op       = OP_MADD;
        lanes_in = '0;
        load_table();
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        repeat (6) @(posedge clk);  // valid_out has to stay low while idle
        for (int r = 0; r < n_rows; r++) begin
            for (int i = 0; i < `PE_LANES; i++) begin
                l[i] = '{a: rows[r].a[i], b: rows[r].b[i], w: rows[r].w[i]};
            end
            issue(rows[r].op, rows[r].valid, l);
        end
        for (int n = 0; n < n_rand; n++) begin
            draw_bits(3, v);
            for (int i = 0; i < `PE_LANES; i++) begin
                draw_coef(c);
                l[i].a = c;
                draw_coef(c);
                l[i].b = c;
                draw_coef(c);
                l[i].w = c;
            end
            issue(pe_op_t'(3'(v % 5)), 1'b1, l);
        end
        @(posedge clk);
        valid_in <= 1'b0;
        waited = 0;
        while (exp_q.size() > 0 && waited < drain_limit) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() > 0) begin
            errors++;
            $display("timeout: %0d results never came out of the pipe", exp_q.size());
        end
        repeat (8) @(posedge clk);  // stray valid_out would show here
        check_equal("result count", results, issued);
        $display("checks %0d, errors %0d, items issued %0d, results seen %0d",
                 checks, errors, issued, results);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
